//--- common/rename_settings.svh
// Rename core sizing
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

////////////////////////////////////////
// register files
////////////////////////////////////////

// architectural registers seen by the program
`define NUM_ARCH_REGS 32
// physical registers behind the map
`define NUM_PHYS_REGS 64
// registers not mapped at reset
`define FREE_LIST_SIZE 32

////////////////////////////////////////
// window and completion
////////////////////////////////////////

// instructions in flight
`define ROB_SIZE 16
// units competing for the data bus
`define NUM_FU 4

`endif

//--- common/rename_pkg.sv
// Rename pipeline types
`default_nettype none

`include "rename_settings.svh"

package rename_pkg;

  // register names
  typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] arch_reg_t;
  typedef logic [$clog2(`NUM_PHYS_REGS)-1:0] phys_reg_t;
  // slot in the reorder buffer
  typedef logic [$clog2(`ROB_SIZE)-1:0] rob_idx_t;

  // instruction as it arrives at dispatch
  typedef struct packed {
    arch_reg_t dest;
    arch_reg_t src_a;
    arch_reg_t src_b;
  } dispatch_req_t;

  // result of renaming one instruction
  typedef struct packed {
    phys_reg_t t1;
    phys_reg_t t2;
    logic      t1_ready;
    logic      t2_ready;
    phys_reg_t t_new;
    phys_reg_t t_old;
    rob_idx_t  rob_idx;
  } rename_rsp_t;

  // what leaves the window at retire
  typedef struct packed {
    arch_reg_t dest;
    phys_reg_t t_new;
    phys_reg_t t_old;
  } retire_t;

  // one window slot
  typedef struct packed {
    retire_t rec;
    logic    complete;
  } rob_entry_t;

endpackage

`default_nettype wire

//--- common/cdb_pkg.sv
// Completion bus types
`default_nettype none

package cdb_pkg;

  // request from one functional unit
  typedef struct packed {
    rename_pkg::phys_reg_t tag;
    rename_pkg::rob_idx_t  rob_idx;
  } fu_req_t;

  // broadcast seen by map table and ROB
  typedef struct packed {
    logic                  valid;
    rename_pkg::phys_reg_t tag;
    rename_pkg::rob_idx_t  rob_idx;
  } cdb_t;

endpackage

`default_nettype wire

//--- rename/map_table.sv
// Register map table
`timescale 1ns/1ns
`default_nettype none

`include "rename_settings.svh"

module map_table (
  input  wire logic                      clock,
  input  wire logic                      reset,
  input  wire rename_pkg::dispatch_req_t lookup,
  input  wire logic                      rename_en,
  input  wire rename_pkg::phys_reg_t     t_new,
  input  wire cdb_pkg::cdb_t             cdb,
  output rename_pkg::phys_reg_t          t1,
  output rename_pkg::phys_reg_t          t2,
  output rename_pkg::phys_reg_t          t_old,
  output logic                           t1_ready,
  output logic                           t2_ready
);

  // arch to phys mapping
  rename_pkg::phys_reg_t map [`NUM_ARCH_REGS];
  // value present, one bit per phys reg
  logic [`NUM_PHYS_REGS-1:0] ready;

  ////////////////////////////////////////
  // lookup
  ////////////////////////////////////////

  // state at start of cycle, no bypass
  always_comb begin
    t1       = map[lookup.src_a];
    t2       = map[lookup.src_b];
    t_old    = map[lookup.dest];
    t1_ready = ready[t1];
    t2_ready = ready[t2];
  end

  ////////////////////////////////////////
  // update
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map, all arch values ready
      for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
        map[i] <= rename_pkg::phys_reg_t'(i);
      end
      for (int i = 0; i < `NUM_PHYS_REGS; i++) begin
        ready[i] <= (i < `NUM_ARCH_REGS);
      end
    end else begin
      // broadcast marks the tag's value present
      if (cdb.valid) begin
        ready[cdb.tag] <= 1'b1;
      end
      // new dest waits for its producer
      if (rename_en) begin
        map[lookup.dest] <= t_new;
        ready[t_new]     <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- rename/free_list.sv
// Free physical register queue
`timescale 1ns/1ns
`default_nettype none

`include "rename_settings.svh"

module free_list (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  pop,
  input  wire logic                  push,
  input  wire rename_pkg::phys_reg_t push_reg,
  output rename_pkg::phys_reg_t      head_reg,
  output logic                       empty
);

  localparam int PTR_W = $clog2(`FREE_LIST_SIZE);
  localparam int CNT_W = $clog2(`FREE_LIST_SIZE + 1);

  rename_pkg::phys_reg_t regs [`FREE_LIST_SIZE];
  // power of two depth, pointers wrap on their own
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] count;

  // next register handed to dispatch
  assign head_reg = regs[head];
  assign empty    = (count == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      // upper half of the phys file starts free, in order
      for (int i = 0; i < `FREE_LIST_SIZE; i++) begin
        regs[i] <= rename_pkg::phys_reg_t'(`NUM_ARCH_REGS + i);
      end
      head  <= '0;
      tail  <= '0;
      count <= CNT_W'(`FREE_LIST_SIZE);
    end else begin
      if (pop) begin
        head <= head + 1'b1;
      end
      // retired t_old goes to the back, FIFO reuse
      if (push) begin
        regs[tail] <= push_reg;
        tail       <= tail + 1'b1;
      end
      // pop and push together leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rob/reorder_buffer.sv
// Reorder buffer
`timescale 1ns/1ns
`default_nettype none

`include "rename_settings.svh"

module reorder_buffer (
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire logic                 alloc,
  input  wire rename_pkg::retire_t  alloc_entry,
  output rename_pkg::rob_idx_t      tail_idx,
  output logic                      full,
  input  wire cdb_pkg::cdb_t        cdb,
  output logic                      retire_valid,
  output rename_pkg::retire_t       retire,
  input  wire logic                 retire_ready
);

  localparam int CNT_W = $clog2(`ROB_SIZE + 1);

  rename_pkg::rob_entry_t entries [`ROB_SIZE];
  rename_pkg::rob_idx_t   head;
  rename_pkg::rob_idx_t   tail;
  logic [CNT_W-1:0]       count;
  logic                   retire_fire;
  logic                   not_empty;

  ////////////////////////////////////////
  // status
  ////////////////////////////////////////

  assign not_empty = (count != '0);
  assign full      = (count == CNT_W'(`ROB_SIZE));
  // slot the next dispatch lands in
  assign tail_idx  = tail;

  // oldest entry leaves only once its result is in
  assign retire_valid = not_empty && entries[head].complete;
  // head slot is untouched while waiting, so the record holds
  assign retire       = entries[head].rec;
  assign retire_fire  = retire_valid && retire_ready;

  ////////////////////////////////////////
  // slot storage
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    // new entry starts incomplete
    if (alloc) begin
      entries[tail].rec      <= alloc_entry;
      entries[tail].complete <= 1'b0;
    end
    // broadcast finishes the entry it names
    if (cdb.valid) begin
      entries[cdb.rob_idx].complete <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // pointers
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (alloc) begin
        tail <= tail + 1'b1;
      end
      // in order, head only
      if (retire_fire) begin
        head <= head + 1'b1;
      end
      case ({alloc, retire_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/complete_select.sv
// Completion select and data bus
`timescale 1ns/1ns
`default_nettype none

`include "rename_settings.svh"

module complete_select (
  input  wire logic                         clock,
  input  wire logic                         reset,
  input  wire logic [`NUM_FU-1:0]           fu_valid,
  input  wire cdb_pkg::fu_req_t [`NUM_FU-1:0] fu_req,
  output logic [`NUM_FU-1:0]                fu_ready,
  output cdb_pkg::cdb_t                     cdb
);

  cdb_pkg::fu_req_t granted;
  logic             bus_valid;
  cdb_pkg::fu_req_t bus_req;

  ////////////////////////////////////////
  // grant
  ////////////////////////////////////////

  // isolate lowest set bit, unit 0 has top priority
  assign fu_ready = fu_valid & (~fu_valid + 1'b1);

  // one-hot mux of the winning request
  always_comb begin
    granted = '0;
    for (int i = 0; i < `NUM_FU; i++) begin
      if (fu_ready[i]) begin
        granted = fu_req[i];
      end
    end
  end

  ////////////////////////////////////////
  // bus register
  ////////////////////////////////////////

  // any valid unit means a grant this cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      bus_valid <= 1'b0;
    end else begin
      bus_valid <= |fu_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (|fu_valid) begin
      bus_req <= granted;
    end
  end

  // granted request goes out a cycle after its grant
  always_comb begin
    cdb.valid   = bus_valid;
    cdb.tag     = bus_req.tag;
    cdb.rob_idx = bus_req.rob_idx;
  end

endmodule

`default_nettype wire

//--- logic/rename_core.sv
// Register rename core
`timescale 1ns/1ns
`default_nettype none

`include "rename_settings.svh"

module rename_core (
  input  wire logic                           clock,
  input  wire logic                           reset,
  input  wire logic                           dispatch_valid,
  input  wire rename_pkg::dispatch_req_t      dispatch_req,
  output logic                                dispatch_ready,
  output rename_pkg::rename_rsp_t             rename_rsp,
  input  wire logic [`NUM_FU-1:0]             fu_valid,
  input  wire cdb_pkg::fu_req_t [`NUM_FU-1:0] fu_req,
  output logic [`NUM_FU-1:0]                  fu_ready,
  output cdb_pkg::cdb_t                       cdb,
  output logic                                retire_valid,
  output rename_pkg::retire_t                 retire,
  input  wire logic                           retire_ready
);

  logic                  fl_empty;
  rename_pkg::phys_reg_t fl_head;
  logic                  rob_full;
  rename_pkg::rob_idx_t  rob_tail;
  rename_pkg::phys_reg_t t1;
  rename_pkg::phys_reg_t t2;
  rename_pkg::phys_reg_t t_old;
  logic                  t1_ready;
  logic                  t2_ready;
  logic                  dispatch_fire;
  logic                  retire_fire;
  rename_pkg::retire_t   alloc_entry;

  ////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////

  // need a free reg and a window slot
  assign dispatch_ready = !fl_empty && !rob_full;
  assign dispatch_fire  = dispatch_valid && dispatch_ready;
  assign retire_fire    = retire_valid && retire_ready;

  // response is combinational with the transfer
  assign rename_rsp = '{t1: t1, t2: t2, t1_ready: t1_ready, t2_ready: t2_ready,
                        t_new: fl_head, t_old: t_old, rob_idx: rob_tail};
  // record kept for retire
  assign alloc_entry = '{dest: dispatch_req.dest, t_new: fl_head, t_old: t_old};

  map_table map0 (
    .clock    (clock),
    .reset    (reset),
    .lookup   (dispatch_req),
    .rename_en(dispatch_fire),
    .t_new    (fl_head),
    .cdb      (cdb),
    .t1       (t1),
    .t2       (t2),
    .t_old    (t_old),
    .t1_ready (t1_ready),
    .t2_ready (t2_ready)
  );

  // retired t_old recycles on the same edge
  free_list free0 (
    .clock   (clock),
    .reset   (reset),
    .pop     (dispatch_fire),
    .push    (retire_fire),
    .push_reg(retire.t_old),
    .head_reg(fl_head),
    .empty   (fl_empty)
  );

  reorder_buffer rob0 (
    .clock       (clock),
    .reset       (reset),
    .alloc       (dispatch_fire),
    .alloc_entry (alloc_entry),
    .tail_idx    (rob_tail),
    .full        (rob_full),
    .cdb         (cdb),
    .retire_valid(retire_valid),
    .retire      (retire),
    .retire_ready(retire_ready)
  );

  complete_select sel0 (
    .clock   (clock),
    .reset   (reset),
    .fu_valid(fu_valid),
    .fu_req  (fu_req),
    .fu_ready(fu_ready),
    .cdb     (cdb)
  );

endmodule

`default_nettype wire

//--- tb/rename_core_asserts.sv
// Rename core assertions
`timescale 1ns/1ns
`default_nettype none

`include "rename_settings.svh"

module rename_core_asserts (
  input wire logic                clock,
  input wire logic                reset,
  input wire logic [`NUM_FU-1:0]  fu_ready,
  input wire logic                dispatch_ready,
  input wire logic [4:0]          rob_count,
  input wire logic                retire_valid,
  input wire logic                retire_ready,
  input wire rename_pkg::retire_t retire
);

  // failed assertions, read by the testbench at the end
  int fails = 0;

  // at most one unit granted per cycle
  grant_onehot: assert property (@(posedge clock) disable iff (reset)
    $onehot0(fu_ready))
    else begin fails++; $error("fu_ready not one-hot"); end

  // full window blocks dispatch
  full_stall: assert property (@(posedge clock) disable iff (reset)
    (rob_count == 5'(`ROB_SIZE)) |-> !dispatch_ready)
    else begin fails++; $error("dispatch_ready high with full ROB"); end

  // record holds under back-pressure
  retire_hold: assert property (@(posedge clock) disable iff (reset)
    (retire_valid && !retire_ready) |=> (retire_valid && $stable(retire)))
    else begin fails++; $error("retire record changed while stalled"); end

endmodule

`default_nettype wire

//--- tb/rename_core_tb.sv
// Rename core testbench
`timescale 1ns/1ns
`default_nettype none

`include "rename_settings.svh"

module rename_core_tb;

  localparam int OP_DISP = 0;
  localparam int OP_COMP = 1;
  localparam int OP_RET  = 2;
  localparam int OP_RAND = 3;

  // table row with the request, unit mask or ready level in arg
  typedef struct packed {
    logic [1:0]              op;
    logic [15:0]             arg;
    logic [15:0]             idx;
    logic                    chk;
    rename_pkg::rename_rsp_t exp;
  } row_t;

  logic clock = 1'b0;
  logic reset = 1'b1;
  logic dispatch_valid = 1'b0;
  rename_pkg::dispatch_req_t dispatch_req = '0;
  logic dispatch_ready;
  rename_pkg::rename_rsp_t rename_rsp;
  logic [`NUM_FU-1:0] fu_valid = '0;
  cdb_pkg::fu_req_t [`NUM_FU-1:0] fu_req = '0;
  logic [`NUM_FU-1:0] fu_ready;
  cdb_pkg::cdb_t cdb;
  logic retire_valid;
  rename_pkg::retire_t retire;
  logic retire_ready = 1'b0;

  row_t rows[$];
  int seed = 83857;
  int errors = 0;
  int nrows = 0;
  int dispatched = 0;

  // reference model state
  rename_pkg::phys_reg_t map_m [`NUM_ARCH_REGS];
  logic [`NUM_PHYS_REGS-1:0] ready_m;
  rename_pkg::phys_reg_t fq[$];
  rename_pkg::retire_t rob_m [`ROB_SIZE];
  logic [`ROB_SIZE-1:0] done_m;
  int rob_head = 0;
  int rob_cnt = 0;

  always #10 clock = ~clock;

  rename_core dut0 (
    .clock(clock), .reset(reset), .dispatch_valid(dispatch_valid),
    .dispatch_req(dispatch_req), .dispatch_ready(dispatch_ready),
    .rename_rsp(rename_rsp), .fu_valid(fu_valid), .fu_req(fu_req),
    .fu_ready(fu_ready), .cdb(cdb), .retire_valid(retire_valid),
    .retire(retire), .retire_ready(retire_ready)
  );

  bind rename_core rename_core_asserts chk0 (
    .clock(clock), .reset(reset), .fu_ready(fu_ready),
    .dispatch_ready(dispatch_ready), .rob_count(rob0.count),
    .retire_valid(retire_valid), .retire_ready(retire_ready), .retire(retire)
  );

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic check_rename(input rename_pkg::rename_rsp_t got,
                              input rename_pkg::rename_rsp_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s rename got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cdb(input cdb_pkg::cdb_t got, input cdb_pkg::cdb_t exp);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: cdb got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_retire(input rename_pkg::retire_t got, input rename_pkg::retire_t exp);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: retire got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_ready(input logic [3:0] got, input logic [3:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  function automatic rename_pkg::rename_rsp_t make_rsp(input int t1, input int t2,
      input logic r1, input logic r2, input int tn, input int to, input int ri);
    make_rsp = '{t1: 6'(t1), t2: 6'(t2), t1_ready: r1, t2_ready: r2,
                 t_new: 6'(tn), t_old: 6'(to), rob_idx: 4'(ri)};
  endfunction

  task automatic add_row(input int op, input int arg, input int idx, input logic chk,
                         input rename_pkg::rename_rsp_t exp);
    rows.push_back('{op: 2'(op), arg: 16'(arg), idx: 16'(idx), chk: chk, exp: exp});
  endtask

  ////////////////////////////////////////
  // operations
  ////////////////////////////////////////

  task automatic dispatch_one(input rename_pkg::dispatch_req_t req, input logic chk,
                              input rename_pkg::rename_rsp_t exp);
    rename_pkg::rename_rsp_t m;
    logic ok;
    int tail;
    ok = (fq.size() > 0) && (rob_cnt < `ROB_SIZE);
    tail = (rob_head + rob_cnt) % `ROB_SIZE;
    m = '{t1: map_m[req.src_a], t2: map_m[req.src_b], t1_ready: ready_m[map_m[req.src_a]],
          t2_ready: ready_m[map_m[req.src_b]], t_new: ok ? fq[0] : '0,
          t_old: map_m[req.dest], rob_idx: 4'(tail)};
    dispatch_valid = 1'b1;
    dispatch_req   = req;
    #1;
    check_ready(4'(dispatch_ready), 4'(ok), "dispatch_ready");
    if (ok) begin
      check_rename(rename_rsp, m, "model");
      if (chk) check_rename(rename_rsp, exp, "table");
    end
    @(posedge clock);
    #2;
    dispatch_valid = 1'b0;
    if (ok) begin
      map_m[req.dest] = m.t_new;
      ready_m[m.t_new] = 1'b0;
      rob_m[tail] = '{dest: req.dest, t_new: m.t_new, t_old: m.t_old};
      done_m[tail] = 1'b0;
      rob_cnt++;
      dispatched++;
      fq.delete(0);
    end
  endtask

  // unit u completes ROB slot idx[4u+3:4u]
  task automatic complete_units(input logic [3:0] mask, input logic [15:0] idx);
    cdb_pkg::fu_req_t q [`NUM_FU];
    cdb_pkg::cdb_t want;
    logic [3:0] left;
    logic [3:0] g;
    logic have;
    for (int u = 0; u < `NUM_FU; u++) begin
      q[u] = '{tag: rob_m[idx[u*4+:4]].t_new, rob_idx: idx[u*4+:4]};
      fu_req[u] = q[u];
    end
    left = mask;
    have = 1'b0;
    want = '0;
    fu_valid = left;
    while (left != 0 || have) begin
      #1;
      if (have) begin
        check_cdb(cdb, want);
        // takes effect on the coming edge
        ready_m[want.tag] = 1'b1;
        done_m[want.rob_idx] = 1'b1;
      end else begin
        // bus idle before the first grant
        check_ready(4'(cdb.valid), 4'b0, "cdb.valid");
      end
      // lowest valid unit wins
      g = '0;
      for (int u = `NUM_FU - 1; u >= 0; u--) begin
        if (left[u]) begin
          g = 4'(1 << u);
        end
      end
      check_ready(fu_ready, g, "fu_ready");
      have = (g != 0);
      for (int u = 0; u < `NUM_FU; u++) begin
        if (g[u]) want = '{valid: 1'b1, tag: q[u].tag, rob_idx: q[u].rob_idx};
      end
      @(posedge clock);
      #2;
      left = left & ~g;
      fu_valid = left;
    end
  endtask

  task automatic retire_one(input logic level);
    logic v;
    v = (rob_cnt > 0) && done_m[rob_head];
    retire_ready = level;
    #1;
    check_ready(4'(retire_valid), 4'(v), "retire_valid");
    if (v) check_retire(retire, rob_m[rob_head]);
    @(posedge clock);
    #2;
    retire_ready = 1'b0;
    if (v && level) begin
      fq.push_back(rob_m[rob_head].t_old);
      rob_head = (rob_head + 1) % `ROB_SIZE;
      rob_cnt--;
    end
  endtask

  // random row resolved against the live model
  task automatic random_step();
    int k;
    int start;
    int n;
    int e;
    logic [3:0] mask;
    logic [15:0] idx;
    k = $unsigned($random(seed)) % 3;
    if (k == 0) begin
      dispatch_one(15'($random(seed)), 1'b0, '0);
    end else if (k == 1) begin
      n = 0;
      mask = '0;
      idx = '0;
      start = (rob_cnt > 0) ? $unsigned($random(seed)) % rob_cnt : 0;
      for (int j = 0; j < rob_cnt; j++) begin
        e = (rob_head + (start + j) % rob_cnt) % `ROB_SIZE;
        if (!done_m[e] && n < `NUM_FU) begin
          idx[n*4+:4] = 4'(e);
          mask[n] = 1'b1;
          n++;
        end
      end
      complete_units(mask & 4'($random(seed)), idx);
    end else begin
      retire_one(($random(seed) & 3) != 0);
    end
  endtask

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  task automatic build_table();
    // reset renaming and dependent read
    add_row(OP_DISP, {5'd3, 5'd1, 5'd2}, 0, 1'b1, make_rsp(1, 2, 1, 1, 32, 3, 0));
    add_row(OP_DISP, {5'd4, 5'd3, 5'd0}, 0, 1'b1, make_rsp(32, 0, 0, 1, 33, 4, 1));
    // units 1 and 3 together, then read both tags
    add_row(OP_COMP, 4'b1010, 16'h1000, 1'b0, '0);
    add_row(OP_DISP, {5'd5, 5'd3, 5'd4}, 0, 1'b1, make_rsp(32, 33, 1, 1, 34, 5, 2));
    add_row(OP_DISP, {5'd6, 5'd0, 5'd0}, 0, 1'b1, make_rsp(0, 0, 1, 1, 35, 6, 3));
    add_row(OP_DISP, {5'd7, 5'd6, 5'd5}, 0, 1'b1, make_rsp(35, 34, 0, 0, 36, 7, 4));
    add_row(OP_RET, 1, 0, 1'b0, '0);
    add_row(OP_RET, 1, 0, 1'b0, '0);
    // out of order completion and in order retire with hold
    add_row(OP_COMP, 4'b0001, 16'h0004, 1'b0, '0);
    add_row(OP_RET, 1, 0, 1'b0, '0);
    add_row(OP_COMP, 4'b0100, 16'h0200, 1'b0, '0);
    add_row(OP_RET, 0, 0, 1'b0, '0);
    add_row(OP_RET, 0, 0, 1'b0, '0);
    add_row(OP_RET, 1, 0, 1'b0, '0);
    add_row(OP_RET, 1, 0, 1'b0, '0);
    add_row(OP_COMP, 4'b0010, 16'h0030, 1'b0, '0);
    add_row(OP_RET, 1, 0, 1'b0, '0);
    add_row(OP_RET, 1, 0, 1'b0, '0);
    // fill the window to a stall and free one slot
    for (int i = 0; i < `ROB_SIZE + 1; i++) begin
      add_row(OP_DISP, {5'(i % 31 + 1), 5'(i), 5'(i + 3)}, 0, 1'b0, '0);
    end
    add_row(OP_COMP, 4'b0001, 16'h0005, 1'b0, '0);
    add_row(OP_RET, 1, 0, 1'b0, '0);
    add_row(OP_DISP, {5'd9, 5'd8, 5'd7}, 0, 1'b0, '0);
    // model run long enough to reissue freed registers
    for (int i = 0; i < 300; i++) add_row(OP_RAND, 0, 0, 1'b0, '0);
  endtask

  initial begin
    for (int i = 0; i < `NUM_ARCH_REGS; i++) map_m[i] = 6'(i);
    for (int i = 0; i < `NUM_PHYS_REGS; i++) ready_m[i] = (i < `NUM_ARCH_REGS);
    for (int i = 0; i < `FREE_LIST_SIZE; i++) fq.push_back(6'(`NUM_ARCH_REGS + i));
    done_m = '0;
    build_table();
    nrows = rows.size();
    repeat (5) @(posedge clock);
    #2;
    reset = 1'b0;
    foreach (rows[i]) begin
      case (rows[i].op)
        2'(OP_DISP): dispatch_one(rows[i].arg[14:0], rows[i].chk, rows[i].exp);
        2'(OP_COMP): complete_units(rows[i].arg[3:0], rows[i].idx);
        2'(OP_RET):  retire_one(rows[i].arg[0]);
        default:     random_step();
      endcase
      $display("row %0d op %0d done, %0d errors so far", i, rows[i].op, errors);
    end
    errors += dut0.chk0.fails;
    // the first freed register is reissued only after every initial one
    if (dispatched <= `FREE_LIST_SIZE) begin
      errors++;
      $display("only %0d dispatches, no freed register was reissued", dispatched);
    end
    $display("%0d rows run, %0d errors", nrows, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog allows 20 cycles per row
  initial begin
    wait (nrows > 0);
    #(nrows * 20 * 20);
    $display("timeout, the run did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+common
common/rename_pkg.sv
common/cdb_pkg.sv
rename/map_table.sv
rename/free_list.sv
rob/reorder_buffer.sv
logic/complete_select.sv
logic/rename_core.sv
tb/rename_core_asserts.sv
tb/rename_core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module rename_core_tb -f build.f
out=$(./obj_dir/Vrename_core_tb)
echo "$out"
echo "$out" | grep -qx "PASS: all tests"
